/* common/main_mem_defines.svh */
`ifndef MAIN_MEM_DEFINES_SVH
`define MAIN_MEM_DEFINES_SVH

////////////////////////////////////////
// bank geometry
////////////////////////////////////////
`define MM_BANKS      8     // banks side by side
`define MM_DEPTH      512   // entries per bank
`define MM_ENTRY_W    9
`define MM_DATA_W     64
`define MM_BYTES      8     // byte enables per word
`define MM_LANE_W     16    // one matrix element
`define MM_INDEX_W    14    // logical index from the ports
`define MM_B_ENTRIES  336   // B matrix depth in every bank

////////////////////////////////////////
// region offsets, in bank entries
////////////////////////////////////////
`define MM_OFF_B          9'd0
`define MM_OFF_SS_STATE   9'd420
`define MM_OFF_RNG_STATE  9'd426
`define MM_OFF_SALT       9'd427
`define MM_OFF_SEED_SE    9'd428
`define MM_OFF_PKH        9'd429
`define MM_OFF_K          9'd431

////////////////////////////////////////
// cells per region, one 64-bit word each
////////////////////////////////////////
`define MM_CNT_SS_STATE   25
`define MM_CNT_RNG_STATE  8
`define MM_CNT_SALT       8
`define MM_CNT_SEED_SE    8
`define MM_CNT_PKH        4
`define MM_CNT_K          4

// latch plus output register in each bank
`define MM_RD_LATENCY     2

`endif

/* common/main_mem_pkg.sv */
`default_nettype none

package main_mem_pkg;

  // access view selected per port and per request
  typedef enum logic [2:0] {
    CMD_B_ROW     = 3'd0, // 64-bit word, one bank
    CMD_B_COL     = 3'd1, // four 16-bit lanes, half of the banks
    CMD_SS_STATE  = 3'd2,
    CMD_RNG_STATE = 3'd3,
    CMD_SALT      = 3'd4,
    CMD_SEED_SE   = 3'd5,
    CMD_PKH       = 3'd6,
    CMD_K         = 3'd7  // last of the single cell regions
  } mm_cmd_e;

endpackage

`default_nettype wire

/* mem_array/mem_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "main_mem_defines.svh"

module mem_bank (
  input  wire                        clk,
  input  wire                        i_rd_en,
  input  wire  [`MM_ENTRY_W-1:0]     i_rd_entry,
  output logic [`MM_DATA_W-1:0]      o_rd_data,
  input  wire                        i_wr_en,
  input  wire  [`MM_BYTES-1:0]       i_wr_byte_en,
  input  wire  [`MM_ENTRY_W-1:0]     i_wr_entry,
  input  wire  [`MM_DATA_W-1:0]      i_wr_data
);

  logic [`MM_DATA_W-1:0] mem [0:`MM_DEPTH-1];
  logic [`MM_DATA_W-1:0] rd_q1;

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      for (int b = 0; b < `MM_BYTES; b++) begin
        if (i_wr_byte_en[b]) begin
          mem[i_wr_entry][b*8 +: 8] <= i_wr_data[b*8 +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // read path, two edges
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      rd_q1 <= mem[i_rd_entry]; // array read
    end
  end

  always_ff @(posedge clk) begin
    o_rd_data <= rd_q1; // output register
  end

endmodule

`default_nettype wire

/* mem_array/mem_bank_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "main_mem_defines.svh"

module mem_bank_array (
  input  wire                                     clk,
  input  wire                                     i_rst_n,
  input  wire  [`MM_ENTRY_W-1:0]                  i_rd_entry,
  input  wire  [`MM_BANKS-1:0]                    i_rd_bank_en,
  input  wire  [`MM_BYTES-1:0]                    i_rd_byte_en,
  output logic [`MM_BANKS-1:0][`MM_DATA_W-1:0]    o_rd_data,
  input  wire  [`MM_ENTRY_W-1:0]                  i_wr_entry,
  input  wire  [`MM_BANKS-1:0]                    i_wr_bank_en,
  input  wire  [`MM_BYTES-1:0]                    i_wr_byte_en,
  input  wire  [`MM_BANKS-1:0][`MM_DATA_W-1:0]    i_wr_data
);

  logic [`MM_BANKS-1:0][`MM_DATA_W-1:0] raw_data;
  logic [`MM_BANKS-1:0]                 bank_en_q [0:`MM_RD_LATENCY-1];
  logic [`MM_BYTES-1:0]                 byte_en_q [0:`MM_RD_LATENCY-1];

  for (genvar k = 0; k < `MM_BANKS; k++) begin : g_bank
    mem_bank bank_inst (
      .clk          (clk),
      .i_rd_en      (i_rd_bank_en[k]),
      .i_rd_entry   (i_rd_entry),
      .o_rd_data    (raw_data[k]),
      .i_wr_en      (i_wr_bank_en[k]),
      .i_wr_byte_en (i_wr_byte_en),
      .i_wr_entry   (i_wr_entry),
      .i_wr_data    (i_wr_data[k])
    );
  end

  // enables follow the data through the banks
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int s = 0; s < `MM_RD_LATENCY; s++) begin
        bank_en_q[s] <= '0;
        byte_en_q[s] <= '0;
      end
    end else begin
      bank_en_q[0] <= i_rd_bank_en;
      byte_en_q[0] <= i_rd_byte_en;
      for (int s = 1; s < `MM_RD_LATENCY; s++) begin
        bank_en_q[s] <= bank_en_q[s-1];
        byte_en_q[s] <= byte_en_q[s-1];
      end
    end
  end

  ////////////////////////////////////////
  // zero what was not asked for
  ////////////////////////////////////////
  always_comb begin
    for (int k = 0; k < `MM_BANKS; k++) begin
      for (int b = 0; b < `MM_BYTES; b++) begin
        o_rd_data[k][b*8 +: 8] = raw_data[k][b*8 +: 8] &
          {8{bank_en_q[`MM_RD_LATENCY-1][k] & byte_en_q[`MM_RD_LATENCY-1][b]}};
      end
    end
  end

endmodule

`default_nettype wire

/* source/main_mem_addr_map.sv */
`timescale 1ns/1ps
`default_nettype none

`include "main_mem_defines.svh"

module main_mem_addr_map (
  input  wire  main_mem_pkg::mm_cmd_e   i_cmd,
  input  wire  [`MM_INDEX_W-1:0]        i_index,
  output logic [`MM_ENTRY_W-1:0]        o_entry,
  output logic [`MM_BANKS-1:0]          o_bank_en,
  output logic [`MM_BYTES-1:0]          o_byte_en,
  output logic                          o_half,
  output logic [1:0]                    o_lane
);

  logic [`MM_ENTRY_W-1:0] offset;

  // column view fields, meaningful for CMD_B_COL only
  assign o_half = i_index[0];
  assign o_lane = i_index[2:1];

  always_comb begin
    case (i_cmd)
      main_mem_pkg::CMD_SS_STATE:  offset = `MM_OFF_SS_STATE;
      main_mem_pkg::CMD_RNG_STATE: offset = `MM_OFF_RNG_STATE;
      main_mem_pkg::CMD_SALT:      offset = `MM_OFF_SALT;
      main_mem_pkg::CMD_SEED_SE:   offset = `MM_OFF_SEED_SE;
      main_mem_pkg::CMD_PKH:       offset = `MM_OFF_PKH;
      main_mem_pkg::CMD_K:         offset = `MM_OFF_K;
      default:                     offset = `MM_OFF_B; // both B views
    endcase
  end

  always_comb begin
    o_entry   = '0;
    o_bank_en = '0;
    o_byte_en = '1;
    case (i_cmd)
      main_mem_pkg::CMD_B_ROW: begin
        o_entry   = i_index[8:0] + offset;
        o_bank_en = 8'b1 << i_index[11:9]; // bank from the upper bits
      end
      main_mem_pkg::CMD_B_COL: begin
        o_entry   = i_index[11:3] + offset;
        o_bank_en = i_index[0] ? 8'hf0 : 8'h0f;
        o_byte_en = 8'b11 << {i_index[2:1], 1'b0}; // one 16-bit lane
      end
      default: begin
        // cells go round the banks first, then down the entries
        o_entry   = i_index[11:3] + offset;
        o_bank_en = 8'b1 << i_index[2:0];
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/main_mem_index_step.sv */
`timescale 1ns/1ps
`default_nettype none

`include "main_mem_defines.svh"

module main_mem_index_step (
  input  wire  main_mem_pkg::mm_cmd_e   i_cmd,
  input  wire  [`MM_INDEX_W-1:0]        i_index,
  output logic [`MM_INDEX_W-1:0]        o_index_next,
  output logic                          o_index_has_next
);

  logic [`MM_INDEX_W-1:0] last_index;
  logic                   row_wrap;

  // a B row ends early, the bank number then steps
  assign row_wrap = (i_cmd == main_mem_pkg::CMD_B_ROW) &&
                    (i_index[8:0] == 9'(`MM_B_ENTRIES - 1));

  always_comb begin
    if (row_wrap) begin
      o_index_next = {i_index[13:9] + 5'd1, 9'd0};
    end else begin
      o_index_next = i_index + 14'd1;
    end
  end

  always_comb begin
    case (i_cmd)
      main_mem_pkg::CMD_B_ROW:
        last_index = 14'((`MM_BANKS - 1) * `MM_DEPTH + `MM_B_ENTRIES - 1);
      main_mem_pkg::CMD_B_COL:
        last_index = 14'(`MM_B_ENTRIES * 8 - 1); // 2 halves x 4 lanes per entry
      main_mem_pkg::CMD_SS_STATE:  last_index = 14'(`MM_CNT_SS_STATE - 1);
      main_mem_pkg::CMD_RNG_STATE: last_index = 14'(`MM_CNT_RNG_STATE - 1);
      main_mem_pkg::CMD_SALT:      last_index = 14'(`MM_CNT_SALT - 1);
      main_mem_pkg::CMD_SEED_SE:   last_index = 14'(`MM_CNT_SEED_SE - 1);
      main_mem_pkg::CMD_PKH:       last_index = 14'(`MM_CNT_PKH - 1);
      default:                     last_index = 14'(`MM_CNT_K - 1);
    endcase
  end

  assign o_index_has_next = (i_index != last_index);

endmodule

`default_nettype wire

/* source/main_mem_read_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "main_mem_defines.svh"

module main_mem_read_port (
  input  wire                                     clk,
  input  wire                                     i_rst_n,
  input  wire                                     i_rd_en,
  input  wire  main_mem_pkg::mm_cmd_e             i_rd_cmd,
  input  wire  [`MM_INDEX_W-1:0]                  i_rd_index,
  output logic [`MM_INDEX_W-1:0]                  o_rd_index_next,
  output logic                                    o_rd_index_has_next,
  output logic [`MM_DATA_W-1:0]                   o_rd_data,
  output logic [`MM_ENTRY_W-1:0]                  o_bank_entry,
  output logic [`MM_BANKS-1:0]                    o_bank_en,
  output logic [`MM_BYTES-1:0]                    o_byte_en,
  input  wire  [`MM_BANKS-1:0][`MM_DATA_W-1:0]    i_bank_data
);

  logic [`MM_BANKS-1:0]  map_bank_en;
  logic                  map_half;
  logic [1:0]            map_lane;
  main_mem_pkg::mm_cmd_e cmd_q  [0:`MM_RD_LATENCY-1];
  logic                  half_q [0:`MM_RD_LATENCY-1];
  logic [1:0]            lane_q [0:`MM_RD_LATENCY-1];
  logic [`MM_DATA_W-1:0] row_word;
  logic [`MM_DATA_W-1:0] col_word;

  main_mem_addr_map addr_map_inst (
    .i_cmd     (i_rd_cmd),
    .i_index   (i_rd_index),
    .o_entry   (o_bank_entry),
    .o_bank_en (map_bank_en),
    .o_byte_en (o_byte_en),
    .o_half    (map_half),
    .o_lane    (map_lane)
  );

  main_mem_index_step index_step_inst (
    .i_cmd            (i_rd_cmd),
    .i_index          (i_rd_index),
    .o_index_next     (o_rd_index_next),
    .o_index_has_next (o_rd_index_has_next)
  );

  assign o_bank_en = map_bank_en & {`MM_BANKS{i_rd_en}};

  // view of each read in flight
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int s = 0; s < `MM_RD_LATENCY; s++) begin
        cmd_q[s]  <= main_mem_pkg::CMD_B_ROW;
        half_q[s] <= 1'b0;
        lane_q[s] <= 2'd0;
      end
    end else begin
      cmd_q[0]  <= i_rd_cmd;
      half_q[0] <= map_half;
      lane_q[0] <= map_lane;
      for (int s = 1; s < `MM_RD_LATENCY; s++) begin
        cmd_q[s]  <= cmd_q[s-1];
        half_q[s] <= half_q[s-1];
        lane_q[s] <= lane_q[s-1];
      end
    end
  end

  ////////////////////////////////////////
  // merge the banks
  ////////////////////////////////////////
  always_comb begin
    row_word = '0;
    for (int k = 0; k < `MM_BANKS; k++) begin
      row_word = row_word | i_bank_data[k]; // unused banks are already zero
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      col_word[i*`MM_LANE_W +: `MM_LANE_W] =
        i_bank_data[{half_q[`MM_RD_LATENCY-1], 2'(i)}]
                   [lane_q[`MM_RD_LATENCY-1]*`MM_LANE_W +: `MM_LANE_W];
    end
  end

  assign o_rd_data = (cmd_q[`MM_RD_LATENCY-1] == main_mem_pkg::CMD_B_COL) ? col_word : row_word;

endmodule

`default_nettype wire

/* source/main_mem_write_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "main_mem_defines.svh"

module main_mem_write_port (
  input  wire                                     i_wr_en,
  input  wire  main_mem_pkg::mm_cmd_e             i_wr_cmd,
  input  wire  [`MM_INDEX_W-1:0]                  i_wr_index,
  input  wire  [`MM_DATA_W-1:0]                   i_wr_data,
  output logic [`MM_INDEX_W-1:0]                  o_wr_index_next,
  output logic                                    o_wr_index_has_next,
  output logic [`MM_ENTRY_W-1:0]                  o_bank_entry,
  output logic [`MM_BANKS-1:0]                    o_bank_en,
  output logic [`MM_BYTES-1:0]                    o_byte_en,
  output logic [`MM_BANKS-1:0][`MM_DATA_W-1:0]    o_bank_data
);

  logic [`MM_BANKS-1:0] map_bank_en;

  main_mem_addr_map addr_map_inst (
    .i_cmd     (i_wr_cmd),
    .i_index   (i_wr_index),
    .o_entry   (o_bank_entry),
    .o_bank_en (map_bank_en),
    .o_byte_en (o_byte_en),
    .o_half    (),
    .o_lane    ()
  );

  main_mem_index_step index_step_inst (
    .i_cmd            (i_wr_cmd),
    .i_index          (i_wr_index),
    .o_index_next     (o_wr_index_next),
    .o_index_has_next (o_wr_index_has_next)
  );

  assign o_bank_en = map_bank_en & {`MM_BANKS{i_wr_en}};

  ////////////////////////////////////////
  // spread the word over the banks
  ////////////////////////////////////////
  always_comb begin
    for (int k = 0; k < `MM_BANKS; k++) begin
      if (i_wr_cmd == main_mem_pkg::CMD_B_COL) begin
        // element k%4 in every lane, byte enables pick the lane
        o_bank_data[k] = {4{i_wr_data[(k % 4)*`MM_LANE_W +: `MM_LANE_W]}};
      end else begin
        o_bank_data[k] = i_wr_data; // only the enabled bank stores it
      end
    end
  end

endmodule

`default_nettype wire

/* source/main_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "main_mem_defines.svh"

module main_mem (
  input  wire                             clk,
  input  wire                             i_rst_n,
  // write side
  input  wire                             i_wr_en,
  input  wire  main_mem_pkg::mm_cmd_e     i_wr_cmd,
  input  wire  [`MM_INDEX_W-1:0]          i_wr_index,
  input  wire  [`MM_DATA_W-1:0]           i_wr_data,
  output logic [`MM_INDEX_W-1:0]          o_wr_index_next,
  output logic                            o_wr_index_has_next,
  // read side
  input  wire                             i_rd_en,
  input  wire  main_mem_pkg::mm_cmd_e     i_rd_cmd,
  input  wire  [`MM_INDEX_W-1:0]          i_rd_index,
  output logic [`MM_DATA_W-1:0]           o_rd_data,
  output logic [`MM_INDEX_W-1:0]          o_rd_index_next,
  output logic                            o_rd_index_has_next
);

  logic [`MM_ENTRY_W-1:0]               wr_entry;
  logic [`MM_BANKS-1:0]                 wr_bank_en;
  logic [`MM_BYTES-1:0]                 wr_byte_en;
  logic [`MM_BANKS-1:0][`MM_DATA_W-1:0] wr_bank_data;
  logic [`MM_ENTRY_W-1:0]               rd_entry;
  logic [`MM_BANKS-1:0]                 rd_bank_en;
  logic [`MM_BYTES-1:0]                 rd_byte_en;
  logic [`MM_BANKS-1:0][`MM_DATA_W-1:0] rd_bank_data;

  main_mem_write_port wr_port_inst (
    .i_wr_en             (i_wr_en),
    .i_wr_cmd            (i_wr_cmd),
    .i_wr_index          (i_wr_index),
    .i_wr_data           (i_wr_data),
    .o_wr_index_next     (o_wr_index_next),
    .o_wr_index_has_next (o_wr_index_has_next),
    .o_bank_entry        (wr_entry),
    .o_bank_en           (wr_bank_en),
    .o_byte_en           (wr_byte_en),
    .o_bank_data         (wr_bank_data)
  );

  main_mem_read_port rd_port_inst (
    .clk                 (clk),
    .i_rst_n             (i_rst_n),
    .i_rd_en             (i_rd_en),
    .i_rd_cmd            (i_rd_cmd),
    .i_rd_index          (i_rd_index),
    .o_rd_index_next     (o_rd_index_next),
    .o_rd_index_has_next (o_rd_index_has_next),
    .o_rd_data           (o_rd_data),
    .o_bank_entry        (rd_entry),
    .o_bank_en           (rd_bank_en),
    .o_byte_en           (rd_byte_en),
    .i_bank_data         (rd_bank_data)
  );

  mem_bank_array bank_array_inst (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_rd_entry   (rd_entry),
    .i_rd_bank_en (rd_bank_en),
    .i_rd_byte_en (rd_byte_en),
    .o_rd_data    (rd_bank_data),
    .i_wr_entry   (wr_entry),
    .i_wr_bank_en (wr_bank_en),
    .i_wr_byte_en (wr_byte_en),
    .i_wr_data    (wr_bank_data)
  );

endmodule

`default_nettype wire

/* tests/main_mem_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "main_mem_defines.svh"

module main_mem_asserts (
  input  wire                          clk,
  input  wire                          i_rst_n,
  input  wire                          i_wr_en,
  input  wire  main_mem_pkg::mm_cmd_e  i_wr_cmd,
  input  wire  [`MM_INDEX_W-1:0]       i_wr_index,
  input  wire  [`MM_INDEX_W-1:0]       i_wr_index_next,
  input  wire                          i_wr_index_has_next,
  input  wire  [`MM_BANKS-1:0]         i_wr_bank_en,
  input  wire                          i_rd_en,
  input  wire  main_mem_pkg::mm_cmd_e  i_rd_cmd,
  input  wire  [`MM_INDEX_W-1:0]       i_rd_index,
  input  wire  [`MM_INDEX_W-1:0]       i_rd_index_next,
  input  wire                          i_rd_index_has_next,
  input  wire  [`MM_DATA_W-1:0]        i_rd_data
);

  int fail_count;

  function automatic logic in_region(main_mem_pkg::mm_cmd_e cmd, logic [`MM_INDEX_W-1:0] idx);
    case (cmd)
      main_mem_pkg::CMD_B_ROW:     return (idx[13:12] == 2'd0) && (idx[8:0] < `MM_B_ENTRIES);
      main_mem_pkg::CMD_B_COL:     return idx < `MM_B_ENTRIES * 8;
      main_mem_pkg::CMD_SS_STATE:  return idx < `MM_CNT_SS_STATE;
      main_mem_pkg::CMD_RNG_STATE: return idx < `MM_CNT_RNG_STATE;
      main_mem_pkg::CMD_SALT:      return idx < `MM_CNT_SALT;
      main_mem_pkg::CMD_SEED_SE:   return idx < `MM_CNT_SEED_SE;
      main_mem_pkg::CMD_PKH:       return idx < `MM_CNT_PKH;
      default:                     return idx < `MM_CNT_K;
    endcase
  endfunction

  // delay stages were cleared, banks hold no request yet
  assert property (@(posedge clk) $rose(i_rst_n) |-> (i_rd_data == '0) ##1 (i_rd_data == '0))
    else begin
      $error("read data not zero in the two cycles after reset");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_wr_en && in_region(i_wr_cmd, i_wr_index) && !in_region(i_wr_cmd, i_wr_index_next))
      |-> !i_wr_index_has_next)
    else begin
      $error("write port has_next set at the end of region %s", i_wr_cmd.name());
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_rd_en && in_region(i_rd_cmd, i_rd_index) && !in_region(i_rd_cmd, i_rd_index_next))
      |-> !i_rd_index_has_next)
    else begin
      $error("read port has_next set at the end of region %s", i_rd_cmd.name());
      fail_count++;
    end

  assert property (@(posedge clk) !i_wr_en |-> (i_wr_bank_en == '0))
    else begin
      $error("bank write enable active without i_wr_en");
      fail_count++;
    end

endmodule

`default_nettype wire

/* tests/main_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "main_mem_defines.svh"

module main_mem_tb;

  // reset, then the five tests in cycles, then margin
  localparam int TIMEOUT_CYCLES = 16 + 4 + 42 + 64 + 120 + 40 + 100;

  logic                   clk;
  logic                   i_rst_n;
  logic                   i_wr_en;
  main_mem_pkg::mm_cmd_e  i_wr_cmd;
  logic [`MM_INDEX_W-1:0] i_wr_index;
  logic [`MM_DATA_W-1:0]  i_wr_data;
  logic [`MM_INDEX_W-1:0] o_wr_index_next;
  logic                   o_wr_index_has_next;
  logic                   i_rd_en;
  main_mem_pkg::mm_cmd_e  i_rd_cmd;
  logic [`MM_INDEX_W-1:0] i_rd_index;
  logic [`MM_DATA_W-1:0]  o_rd_data;
  logic [`MM_INDEX_W-1:0] o_rd_index_next;
  logic                   o_rd_index_has_next;

  logic [`MM_DATA_W-1:0]  shadow [0:`MM_BANKS-1][0:`MM_DEPTH-1];
  logic [15:0]            lfsr_state = 16'd92;
  logic [`MM_DATA_W-1:0]  exp_q0;
  logic [`MM_DATA_W-1:0]  exp_q1;
  logic                   vld_q0 = 1'b0;
  logic                   vld_q1 = 1'b0;
  logic [`MM_INDEX_W-1:0] wr_next;
  logic [`MM_INDEX_W-1:0] rd_next;
  logic                   wr_has_next;
  logic                   rd_has_next;
  int                     err_count = 0;
  int                     check_count = 0;
  int                     tests_failed = 0;
  int                     cycle_count = 0;

  main_mem main_mem_inst (.*);

  bind main_mem main_mem_asserts asserts_inst (
    .clk                 (clk),
    .i_rst_n             (i_rst_n),
    .i_wr_en             (i_wr_en),
    .i_wr_cmd            (i_wr_cmd),
    .i_wr_index          (i_wr_index),
    .i_wr_index_next     (o_wr_index_next),
    .i_wr_index_has_next (o_wr_index_has_next),
    .i_wr_bank_en        (wr_bank_en),
    .i_rd_en             (i_rd_en),
    .i_rd_cmd            (i_rd_cmd),
    .i_rd_index          (i_rd_index),
    .i_rd_index_next     (o_rd_index_next),
    .i_rd_index_has_next (o_rd_index_has_next),
    .i_rd_data           (o_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the run did not reach its end", cycle_count);
    $display("SOME TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic logic [`MM_DATA_W-1:0] random_word();
    logic [`MM_DATA_W-1:0] w;
    w = '0;
    for (int i = 0; i < `MM_DATA_W; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[`MM_DATA_W-2:0], lfsr_state[0]};
    end
    return w;
  endfunction

  function automatic int region_offset(main_mem_pkg::mm_cmd_e cmd);
    case (cmd)
      main_mem_pkg::CMD_SS_STATE:  return `MM_OFF_SS_STATE;
      main_mem_pkg::CMD_RNG_STATE: return `MM_OFF_RNG_STATE;
      main_mem_pkg::CMD_SALT:      return `MM_OFF_SALT;
      main_mem_pkg::CMD_SEED_SE:   return `MM_OFF_SEED_SE;
      main_mem_pkg::CMD_PKH:       return `MM_OFF_PKH;
      main_mem_pkg::CMD_K:         return `MM_OFF_K;
      default:                     return 0;
    endcase
  endfunction

  function automatic int region_last(main_mem_pkg::mm_cmd_e cmd);
    case (cmd)
      main_mem_pkg::CMD_B_ROW:     return 7 * `MM_DEPTH + `MM_B_ENTRIES - 1; // bank 7, entry 335
      main_mem_pkg::CMD_B_COL:     return `MM_B_ENTRIES * 8 - 1;
      main_mem_pkg::CMD_SS_STATE:  return `MM_CNT_SS_STATE - 1;
      main_mem_pkg::CMD_RNG_STATE: return `MM_CNT_RNG_STATE - 1;
      main_mem_pkg::CMD_SALT:      return `MM_CNT_SALT - 1;
      main_mem_pkg::CMD_SEED_SE:   return `MM_CNT_SEED_SE - 1;
      main_mem_pkg::CMD_PKH:       return `MM_CNT_PKH - 1;
      default:                     return `MM_CNT_K - 1;
    endcase
  endfunction

  // {has_next, next}
  function automatic logic [`MM_INDEX_W:0] ref_step(main_mem_pkg::mm_cmd_e cmd, int idx);
    int nxt;
    if (cmd == main_mem_pkg::CMD_B_ROW && idx % `MM_DEPTH == `MM_B_ENTRIES - 1) begin
      nxt = (idx / `MM_DEPTH + 1) * `MM_DEPTH; // on to entry 0 of the next bank
    end else begin
      nxt = idx + 1;
    end
    return {idx != region_last(cmd), 14'(nxt)};
  endfunction

  function automatic logic [`MM_DATA_W-1:0] ref_read(main_mem_pkg::mm_cmd_e cmd,
                                                     logic [`MM_INDEX_W-1:0] idx);
    logic [`MM_DATA_W-1:0] w;
    w = '0;
    case (cmd)
      main_mem_pkg::CMD_B_ROW: w = shadow[idx[11:9]][idx[8:0]];
      main_mem_pkg::CMD_B_COL: begin
        for (int i = 0; i < 4; i++) begin
          w[16*i +: 16] = shadow[4*idx[0] + i][idx[11:3]][16*idx[2:1] +: 16];
        end
      end
      default: w = shadow[idx[2:0]][region_offset(cmd) + idx[11:3]];
    endcase
    return w;
  endfunction

  task automatic store_shadow(input main_mem_pkg::mm_cmd_e cmd,
                              input logic [`MM_INDEX_W-1:0] idx,
                              input logic [`MM_DATA_W-1:0] data);
    case (cmd)
      main_mem_pkg::CMD_B_ROW: shadow[idx[11:9]][idx[8:0]] = data;
      main_mem_pkg::CMD_B_COL: begin
        for (int i = 0; i < 4; i++) begin
          shadow[4*idx[0] + i][idx[11:3]][16*idx[2:1] +: 16] = data[16*i +: 16];
        end
      end
      default: shadow[idx[2:0]][region_offset(cmd) + idx[11:3]] = data;
    endcase
  endtask

  task automatic check_index_step(input string port, input main_mem_pkg::mm_cmd_e cmd,
                                  input logic [`MM_INDEX_W-1:0] idx,
                                  input logic [`MM_INDEX_W-1:0] got_next,
                                  input logic got_has);
    logic [`MM_INDEX_W:0] exp;
    exp = ref_step(cmd, idx);
    check_count += 2;
    assert (got_next === exp[`MM_INDEX_W-1:0]) else begin
      $display("error o_%s_index_next: got %h expected %h", port, got_next,
               exp[`MM_INDEX_W-1:0]);
      err_count++;
    end
    assert (got_has === exp[`MM_INDEX_W]) else begin
      $display("error o_%s_index_has_next: got %h expected %h", port, got_has,
               exp[`MM_INDEX_W]);
      err_count++;
    end
  endtask

  ////////////////////////////////////////
  // compare process
  ////////////////////////////////////////
  always @(negedge clk) begin : compare_reads
    if (!i_rst_n) begin
      vld_q0 = 1'b0;
      vld_q1 = 1'b0;
    end else begin
      check_count++;
      if (vld_q1) begin
        assert (o_rd_data === exp_q1) else begin
          $display("error o_rd_data: got %h expected %h", o_rd_data, exp_q1);
          err_count++;
        end
      end else begin
        assert (o_rd_data === '0) else begin // nothing due, all bytes masked
          $display("error o_rd_data: got %h expected %h", o_rd_data, 64'h0);
          err_count++;
        end
      end
      exp_q1 = exp_q0;
      vld_q1 = vld_q0;
      vld_q0 = i_rd_en;
      if (i_rd_en) begin
        exp_q0 = ref_read(i_rd_cmd, i_rd_index); // before this cycle's write
        check_index_step("rd", i_rd_cmd, i_rd_index, o_rd_index_next, o_rd_index_has_next);
      end
      if (i_wr_en) begin
        check_index_step("wr", i_wr_cmd, i_wr_index, o_wr_index_next, o_wr_index_has_next);
        store_shadow(i_wr_cmd, i_wr_index, i_wr_data);
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  task automatic write_word(input main_mem_pkg::mm_cmd_e cmd,
                            input logic [`MM_INDEX_W-1:0] idx,
                            input logic [`MM_DATA_W-1:0] data);
    @(posedge clk);
    i_wr_en    <= 1'b1;
    i_wr_cmd   <= cmd;
    i_wr_index <= idx;
    i_wr_data  <= data;
    @(negedge clk);
    wr_next     = o_wr_index_next;
    wr_has_next = o_wr_index_has_next;
  endtask

  task automatic read_word(input main_mem_pkg::mm_cmd_e cmd, input logic [`MM_INDEX_W-1:0] idx);
    @(posedge clk);
    i_rd_en    <= 1'b1;
    i_rd_cmd   <= cmd;
    i_rd_index <= idx;
    @(negedge clk);
    rd_next     = o_rd_index_next;
    rd_has_next = o_rd_index_has_next;
  endtask

  task automatic idle_ports();
    @(posedge clk);
    i_wr_en <= 1'b0;
    i_rd_en <= 1'b0;
  endtask

  task automatic drain_reads();
    idle_ports();
    while (vld_q0 || vld_q1) @(posedge clk);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      $display("test %-20s ok", name);
    end else begin
      $display("test %-20s failed with %0d errors", name, err_count - errs_before);
      tests_failed++;
    end
  endtask

  task automatic test_reset_zero();
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check_count++;
      assert (o_rd_data === '0) else begin
        $display("error o_rd_data: got %h expected %h", o_rd_data, 64'h0);
        err_count++;
      end
    end
  endtask

  task automatic test_row_stream();
    logic [`MM_INDEX_W-1:0] idx;
    idx = 14'd330; // crosses entry 335 of bank 0
    for (int n = 0; n < 12; n++) begin
      write_word(main_mem_pkg::CMD_B_ROW, idx, random_word());
      idx = wr_next;
    end
    idx = 14'(7 * `MM_DEPTH + 330);
    for (int n = 0; n < 6; n++) begin
      write_word(main_mem_pkg::CMD_B_ROW, idx, random_word());
      idx = wr_next;
    end
    check_count++;
    assert (wr_has_next === 1'b0) else begin
      $display("error o_wr_index_has_next: got %h expected %h", wr_has_next, 1'b0);
      err_count++;
    end
    idle_ports();
    idx = 14'd330;
    for (int n = 0; n < 12; n++) begin
      read_word(main_mem_pkg::CMD_B_ROW, idx);
      idx = rd_next;
    end
    idx = 14'(7 * `MM_DEPTH + 330);
    for (int n = 0; n < 6; n++) begin
      read_word(main_mem_pkg::CMD_B_ROW, idx);
      idx = rd_next;
    end
    drain_reads();
  endtask

  task automatic test_col_lanes();
    for (int e = 5; e <= 6; e++) begin
      for (int k = 0; k < `MM_BANKS; k++) begin
        write_word(main_mem_pkg::CMD_B_ROW, 14'(k * `MM_DEPTH + e), random_word());
      end
    end
    for (int c = 40; c < 48; c++) begin
      write_word(main_mem_pkg::CMD_B_COL, 14'(c), random_word()); // entry 5, every lane
    end
    write_word(main_mem_pkg::CMD_B_COL, 14'(48 + 2), random_word()); // half 0 lane 1
    write_word(main_mem_pkg::CMD_B_COL, 14'(48 + 7), random_word()); // half 1 lane 3
    write_word(main_mem_pkg::CMD_B_COL, 14'(`MM_B_ENTRIES * 8 - 1), random_word());
    check_count++;
    assert (wr_has_next === 1'b0) else begin
      $display("error o_wr_index_has_next: got %h expected %h", wr_has_next, 1'b0);
      err_count++;
    end
    idle_ports();
    for (int c = 40; c < 56; c++) begin
      read_word(main_mem_pkg::CMD_B_COL, 14'(c));
    end
    for (int e = 5; e <= 6; e++) begin
      for (int k = 0; k < `MM_BANKS; k++) begin
        read_word(main_mem_pkg::CMD_B_ROW, 14'(k * `MM_DEPTH + e));
      end
    end
    drain_reads();
  endtask

  task automatic test_cells();
    main_mem_pkg::mm_cmd_e  cmd;
    logic [`MM_INDEX_W-1:0] idx;
    int                     n;
    for (int r = 0; r < 6; r++) begin
      cmd = main_mem_pkg::mm_cmd_e'(3'(r + 2)); // the six cell regions
      idx = '0;
      n = 0;
      do begin
        write_word(cmd, idx, random_word());
        idx = wr_next;
        n++;
      end while (wr_has_next && n < 32);
      check_count++;
      assert (n == region_last(cmd) + 1) else begin
        $display("write stream for %s ended after %0d cells instead of %0d",
                 cmd.name(), n, region_last(cmd) + 1);
        err_count++;
      end
    end
    idle_ports();
    for (int r = 0; r < 6; r++) begin
      cmd = main_mem_pkg::mm_cmd_e'(3'(r + 2));
      idx = '0;
      n = 0;
      do begin
        read_word(cmd, idx);
        idx = rd_next;
        n++;
      end while (rd_has_next && n < 32);
    end
    drain_reads();
  endtask

  task automatic test_back_to_back();
    for (int j = 0; j < 12; j++) begin
      read_word(main_mem_pkg::CMD_B_ROW, 14'(330 + j % 6));
      read_word(main_mem_pkg::CMD_B_COL, 14'(40 + j % 8));
      read_word(main_mem_pkg::CMD_SS_STATE, 14'(j));
    end
    drain_reads();
  endtask

  initial begin
    int errs_before;
    int total_errors;
    i_rst_n    = 1'b0;
    i_wr_en    = 1'b0;
    i_wr_cmd   = main_mem_pkg::CMD_B_ROW;
    i_wr_index = '0;
    i_wr_data  = '0;
    i_rd_en    = 1'b0;
    i_rd_cmd   = main_mem_pkg::CMD_B_ROW;
    i_rd_index = '0;
    repeat (16) @(posedge clk);
    i_rst_n <= 1'b1;

    errs_before = err_count;
    test_reset_zero();
    finish_test("reset_zero", errs_before);
    errs_before = err_count;
    test_row_stream();
    finish_test("b_row_stream", errs_before);
    errs_before = err_count;
    test_col_lanes();
    finish_test("b_col_lanes", errs_before);
    errs_before = err_count;
    test_cells();
    finish_test("cell_regions", errs_before);
    errs_before = err_count;
    test_back_to_back();
    finish_test("back_to_back_reads", errs_before);

    total_errors = err_count + main_mem_inst.asserts_inst.fail_count;
    $display("tests 5, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_failed, check_count, err_count, main_mem_inst.asserts_inst.fail_count);
    if (total_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+common
common/main_mem_pkg.sv
mem_array/mem_bank.sv
mem_array/mem_bank_array.sv
source/main_mem_addr_map.sv
source/main_mem_index_step.sv
source/main_mem_read_port.sv
source/main_mem_write_port.sv
source/main_mem.sv
tests/main_mem_asserts.sv
tests/main_mem_tb.sv

/* Bender.yml */
package:
  name: main_mem

export_include_dirs:
  - common

sources:
  - common/main_mem_pkg.sv
  - mem_array/mem_bank.sv
  - mem_array/mem_bank_array.sv
  - source/main_mem_addr_map.sv
  - source/main_mem_index_step.sv
  - source/main_mem_read_port.sv
  - source/main_mem_write_port.sv
  - source/main_mem.sv
  - target: test
    files:
      - tests/main_mem_asserts.sv
      - tests/main_mem_tb.sv
